//--- tb/ex_alu_stim.txt
// grp op src_a    src_b    sa hilo             flush expected         ovf
// op in decimal, flush = cycles after issue (0 none), group 7 flushes on an exception
1  0 f0f01234 0ff0ff00 00 0000000000000000 0 0000000000f01200 0
1  2 f0f01234 0ff0ff00 00 0000000000000000 0 00000000000f00cb 0
1  3 f0f01234 0ff0ff00 00 0000000000000000 0 00000000ff00ed34 0
1  5 ffffffff 00000002 00 0000000000000000 0 0000000000000001 0
1  7 00000001 00000003 00 0000000000000000 0 00000000fffffffe 0
1  8 fffffffe 00000001 00 0000000000000000 0 0000000000000001 0
1  9 fffffffe 00000001 00 0000000000000000 0 0000000000000000 0
1 10 00000024 000000f1 1f 0000000000000000 0 0000000000000f10 0
1 12 00000008 80001000 10 0000000000000000 0 00000000ff800010 0
1 14 00000010 80001000 04 0000000000000000 0 0000000008000100 0
1 15 00000001 80000000 1f 0000000000000000 0 00000000ffffffff 0
1 16 00000000 1234abcd 00 0000000000000000 0 00000000abcd0000 0
1 17 deadbeef 00000000 00 0000000000000000 0 00000000deadbeef 0
2  4 7fffffff 00000001 00 0000000000000000 0 0000000080000000 1
2  5 7fffffff 00000001 00 0000000000000000 0 0000000080000000 0
2  6 80000000 00000001 00 0000000000000000 0 000000007fffffff 1
2  7 80000000 00000001 00 0000000000000000 0 000000007fffffff 0
2  4 ffffffff ffffffff 00 0000000000000000 0 00000000fffffffe 0
3 20 fffffffd 00000007 00 0000000000000000 0 ffffffffffffffeb 0
3 21 fffffffd 00000007 00 0000000000000000 0 00000006ffffffeb 0
3 20 80000000 80000000 00 0000000000000000 0 4000000000000000 0
4 22 fffffff9 00000002 00 0000000000000000 0 fffffffffffffffd 0
4 23 fffffff9 00000002 00 0000000000000000 0 000000017ffffffc 0
4 22 00000007 fffffffe 00 0000000000000000 0 00000001fffffffd 0
4 22 fffffff9 00000000 00 0000000000000000 0 fffffff900000001 0
5 18 11112222 00000000 00 aaaabbbbccccdddd 0 11112222ccccdddd 0
5 19 11112222 00000000 00 aaaabbbbccccdddd 0 aaaabbbb11112222 0
6 22 00000064 00000007 00 0000000000000000 5 0000000000000000 0
6 17 00005a5a 00000000 00 0000000000000000 0 0000000000005a5a 0
6 23 00000064 00000007 00 0000000000000000 0 000000020000000e 0
7 20 12345678 00000009 00 0000000000000000 6 0000000000000000 0
7  4 00000010 00000020 00 0000000000000000 0 0000000000000030 0

//--- filelist.f
+incdir+hw
hw/ex_pkg.sv
hw/alu_simple.sv
hw/div_radix2.sv
hw/mult_seq.sv
hw/ex_alu.sv
tb/ex_alu_tb.sv

//--- run_sim.sh
#!/bin/sh
# build and run the ex_alu testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/100ps \
    -f filelist.f --top-module ex_alu_tb -o ex_alu_sim

out=$(./obj_dir/ex_alu_sim)
printf '%s\n' "$out"

if printf '%s\n' "$out" | grep -qx "Simulation passed"; then
    exit 0
else
    exit 1
fi

//--- tb/ex_alu_tb.sv
`include "ex_defines.svh"

module ex_alu_tb
    import ex_pkg::*;
();

    timeunit 1ns;
    timeprecision 100ps;

    logic    clk;
    logic    rst;
    logic    issue;
    logic    flush;
    logic    flush_exception;
    alu_op_t op;
    word_t   src_a;
    word_t   src_b;
    shamt_t  sa;
    dword_t  hilo;
    logic    stall;
    logic    div_stall;
    logic    mult_stall;
    dword_t  result;
    logic    overflow;

    // one entry per stimulus line
    int      grp_q[$];
    alu_op_t op_q[$];
    word_t   a_q[$];
    word_t   b_q[$];
    shamt_t  sa_q[$];
    dword_t  hilo_q[$];
    int      flush_q[$];
    dword_t  exp_q[$];
    logic    ovf_q[$];

    int      err_cnt = 0;
    int      tests_ok = 0;
    int      tests_bad = 0;
    logic    loaded = 1'b0;

    ex_alu ex_alu_i (
        .clk             (clk),
        .rst             (rst),
        .issue           (issue),
        .flush           (flush),
        .flush_exception (flush_exception),
        .op              (op),
        .src_a           (src_a),
        .src_b           (src_b),
        .sa              (sa),
        .hilo            (hilo),
        .stall           (stall),
        .div_stall       (div_stall),
        .mult_stall      (mult_stall),
        .result          (result),
        .overflow        (overflow)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    // ops that hold the pipeline until their unit is done
    function automatic logic is_multi(input alu_op_t o);
        return o == `ALU_SIGNED_DIV || o == `ALU_UNSIGNED_DIV ||
               o == `ALU_SIGNED_MULT || o == `ALU_UNSIGNED_MULT;
    endfunction

    function automatic logic is_divide(input alu_op_t o);
        return o == `ALU_SIGNED_DIV || o == `ALU_UNSIGNED_DIV;
    endfunction

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("Simulation failed");
        $finish;
    endtask

    task automatic load_stim(output logic ok);
        int     fd;
        int     n;
        string  line;
        int     grp;
        int     opc;
        int     fl;
        int     ovf;
        word_t  a;
        word_t  b;
        shamt_t s;
        dword_t h;
        dword_t e;
        ok = 1'b0;
        fd = $fopen("tb/ex_alu_stim.txt", "r");
        if (fd != 0) begin
            while (!$feof(fd)) begin
                n = $fgets(line, fd);
                if (n > 0) begin
                    // comment and blank lines never scan all nine fields
                    n = $sscanf(line, "%d %d %h %h %h %h %d %h %d",
                                grp, opc, a, b, s, h, fl, e, ovf);
                    if (n == 9) begin
                        grp_q.push_back(grp);
                        op_q.push_back(alu_op_t'(opc));
                        a_q.push_back(a);
                        b_q.push_back(b);
                        sa_q.push_back(s);
                        hilo_q.push_back(h);
                        flush_q.push_back(fl);
                        exp_q.push_back(e);
                        ovf_q.push_back(ovf[0]);
                    end
                end
            end
            $fclose(fd);
            ok = (grp_q.size() > 0);
        end
    endtask

    task automatic check_value(input int idx, input string what, input dword_t expv,
                               input dword_t got);
        assert (got === expv) else begin
            $display("[FAIL] %0d ns test %0d: %s expected %h, observed %h",
                     $time, idx, what, expv, got);
            err_cnt++;
        end
    endtask

    task automatic check_cond(input int idx, input logic cond, input string what);
        assert (cond) else begin
            $display("test %0d: %s at %0d ns", idx, what, $time);
            err_cnt++;
        end
    endtask

    // abort a running unit after flush_q cycles
    task automatic flush_run(input int idx);
        logic exception;
        logic released;
        exception = (grp_q[idx] == 7);   // group 7 is a mem stage exception
        released  = 1'b0;
        repeat (flush_q[idx]) begin
            @(posedge clk);
            #1;
            issue = 1'b0;
        end
        flush           = 1'b1;
        flush_exception = exception;
        @(negedge clk);
        if (exception)
            check_cond(idx, !stall && !mult_stall, "flush_exception did not mask stall");
        else
            check_cond(idx, stall && div_stall && !mult_stall,
                       "stall was not held while the divide ran");
        @(posedge clk);
        #1;
        flush           = 1'b0;
        flush_exception = 1'b0;
        // aborted unit sits idle, so done never comes for the held op
        repeat (`DIV_STEPS + 2) begin
            @(negedge clk);
            if (!stall)
                released = 1'b1;
        end
        check_cond(idx, !released, "the flushed unit ran on to done");
    endtask

    task automatic run_test(input int idx);
        int   errs_at_start;
        int   waited;
        logic multi;
        logic divide;
        errs_at_start = err_cnt;
        waited        = 0;
        multi         = is_multi(op_q[idx]);
        divide        = is_divide(op_q[idx]);
        @(posedge clk);
        #1;
        op    = op_q[idx];
        src_a = a_q[idx];
        src_b = b_q[idx];
        sa    = sa_q[idx];
        hilo  = hilo_q[idx];
        issue = 1'b1;
        if (flush_q[idx] != 0) begin
            flush_run(idx);
        end else begin
            @(negedge clk);
            while (stall) begin
                check_cond(idx, div_stall == divide && mult_stall == !divide,
                           "stall came from the wrong unit");
                @(posedge clk);
                #1;
                issue = 1'b0;   // one issue per instruction
                waited++;
                @(negedge clk);
            end
            if (multi)
                check_cond(idx, waited > 0, "stall never rose for a multi-cycle op");
            else
                check_cond(idx, waited == 0, "stall rose for a single-cycle op");
            check_value(idx, "result", exp_q[idx], result);
            check_value(idx, "overflow", dword_t'(ovf_q[idx]), dword_t'(overflow));
        end
        @(posedge clk);
        #1;
        issue = 1'b0;
        op    = `ALU_PASS;   // flushed or finished slot turns into a bubble
        if (err_cnt == errs_at_start) begin
            tests_ok++;
            $display("test %0d group %0d op %0d: ok", idx, grp_q[idx], op_q[idx]);
        end else begin
            tests_bad++;
            $display("test %0d group %0d op %0d: FAILED", idx, grp_q[idx], op_q[idx]);
        end
    endtask

    initial begin : watchdog
        int limit;
        wait (loaded);
        limit = grp_q.size() * (`DIV_STEPS + 4) + 20;   // worst case is a full divide
        repeat (limit) @(posedge clk);
        abort_run("run timed out, the DUT never released stall");
    end

    initial begin : main
        logic ok;
        rst             = 1'b1;
        issue           = 1'b0;
        flush           = 1'b0;
        flush_exception = 1'b0;
        op              = `ALU_PASS;
        src_a           = '0;
        src_b           = '0;
        sa              = '0;
        hilo            = '0;
        load_stim(ok);
        if (!ok) begin
            abort_run("could not read any test from tb/ex_alu_stim.txt");
        end else begin
            loaded = 1'b1;
            repeat (10) @(posedge clk);
            #1;
            rst = 1'b0;
            for (int i = 0; i < grp_q.size(); i++)
                run_test(i);
            $display("%0d tests, %0d passed, %0d failed, %0d failed checks",
                     grp_q.size(), tests_ok, tests_bad, err_cnt);
            if (tests_bad == 0 && err_cnt == 0)
                $display("Simulation passed");
            else
                $display("Simulation failed");
            $finish;
        end
    end

endmodule

//--- hw/ex_alu.sv
`include "ex_defines.svh"

module ex_alu
    import ex_pkg::*;
(
    input  logic    clk,
    input  logic    rst,
    input  logic    issue,
    input  logic    flush,
    input  logic    flush_exception,
    input  alu_op_t op,
    input  word_t   src_a,
    input  word_t   src_b,
    input  shamt_t  sa,
    input  dword_t  hilo,
    output logic    stall,
    output logic    div_stall,
    output logic    mult_stall,
    output dword_t  result,
    output logic    overflow
);

    logic   is_div;
    logic   is_mult;
    logic   is_mthi;
    logic   is_mtlo;
    logic   is_simple;
    logic   div_start;
    logic   div_sign;
    logic   div_done;
    dword_t div_result;
    logic   mult_start;
    logic   mult_sign;
    logic   mult_done;
    dword_t mult_result;
    word_t  alu_result;

    // operation class decode
    assign is_div    = (op == `ALU_SIGNED_DIV) || (op == `ALU_UNSIGNED_DIV);
    assign is_mult   = (op == `ALU_SIGNED_MULT) || (op == `ALU_UNSIGNED_MULT);
    assign is_mthi   = (op == `ALU_MTHI);
    assign is_mtlo   = (op == `ALU_MTLO);
    assign is_simple = !(is_div || is_mult || is_mthi || is_mtlo);

    assign div_sign   = (op == `ALU_SIGNED_DIV);
    assign mult_sign  = (op == `ALU_SIGNED_MULT);
    assign div_start  = issue & is_div & ~flush;
    assign mult_start = issue & is_mult & ~flush;

    // exception in mem stage releases the hold
    assign div_stall  = is_div & ~div_done & ~flush_exception;
    assign mult_stall = is_mult & ~mult_done & ~flush_exception;
    assign stall      = div_stall | mult_stall;

    alu_simple alu_unit (
        .op       (op),
        .src_a    (src_a),
        .src_b    (src_b),
        .sa       (sa),
        .result   (alu_result),
        .overflow (overflow)
    );

    div_radix2 div_unit (
        .clk      (clk),
        .rst      (rst),
        .flush    (flush),
        .start    (div_start),
        .sign     (div_sign),
        .dividend (src_a),
        .divisor  (src_b),
        .done     (div_done),
        .result   (div_result)
    );

    mult_seq mult_unit (
        .clk          (clk),
        .rst          (rst),
        .flush        (flush),
        .start        (mult_start),
        .sign         (mult_sign),
        .multiplicand (src_a),
        .multiplier   (src_b),
        .done         (mult_done),
        .result       (mult_result)
    );

    always_comb begin
        if (is_div)
            result = div_result;               // {rem, quo}
        else if (is_mult)
            result = mult_result;
        else if (is_mthi)
            result = {src_a, hilo[31:0]};
        else if (is_mtlo)
            result = {hilo[63:32], src_a};
        else
            result = {32'h0, alu_result};
    end

    a_simple_no_stall: assert property (@(posedge clk) disable iff (rst)
        is_simple |-> !stall);

endmodule

//--- hw/mult_seq.sv
`include "ex_defines.svh"

module mult_seq
    import ex_pkg::*;
(
    input  logic   clk,
    input  logic   rst,
    input  logic   flush,
    input  logic   start,
    input  logic   sign,
    input  word_t  multiplicand,
    input  word_t  multiplier,
    output logic   done,
    output dword_t result
);

    localparam int CNT_W = $clog2(`MULT_STEPS + 1);

    mult_state_t      state;
    logic [CNT_W-1:0] step_cnt;

    dword_t mcand;     // shifts left two bits per step
    word_t  mplier;    // consumed from the bottom
    dword_t acc;
    logic   prod_neg;
    dword_t pp;        // radix-4 partial product

    always_comb begin
        case (mplier[1:0])
            2'b00:   pp = '0;
            2'b01:   pp = mcand;
            2'b10:   pp = mcand << 1;
            default: pp = mcand + (mcand << 1);   // 3x
        endcase
    end

    assign done = (state == MULT_DONE);

    always_ff @(posedge clk) begin
        if (rst || flush) begin
            state    <= MULT_IDLE;
            step_cnt <= '0;
        end else begin
            case (state)
                MULT_IDLE, MULT_DONE: begin
                    if (start) begin
                        state    <= MULT_BUSY;
                        step_cnt <= '0;
                    end else begin
                        state <= MULT_IDLE;
                    end
                end
                MULT_BUSY: begin
                    step_cnt <= step_cnt + 1'b1;
                    if (step_cnt == CNT_W'(`MULT_STEPS - 1))
                        state <= MULT_FIX;
                end
                MULT_FIX: state <= MULT_DONE;
                default:  state <= MULT_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (start) begin
            mcand    <= {32'h0, (sign && multiplicand[31]) ? -multiplicand : multiplicand};
            mplier   <= (sign && multiplier[31]) ? -multiplier : multiplier;
            acc      <= '0;
            prod_neg <= sign & (multiplicand[31] ^ multiplier[31]);
        end else if (state == MULT_BUSY) begin
            acc    <= acc + pp;
            mcand  <= mcand << 2;
            mplier <= mplier >> 2;
        end else if (state == MULT_FIX) begin
            result <= prod_neg ? -acc : acc;
        end
    end

    a_cnt_range: assert property (@(posedge clk) disable iff (rst)
        step_cnt <= CNT_W'(`MULT_STEPS));

    a_done_pulse: assert property (@(posedge clk) disable iff (rst)
        done |=> !done);

endmodule

//--- hw/div_radix2.sv
`include "ex_defines.svh"

module div_radix2
    import ex_pkg::*;
(
    input  logic   clk,
    input  logic   rst,
    input  logic   flush,
    input  logic   start,
    input  logic   sign,
    input  word_t  dividend,
    input  word_t  divisor,
    output logic   done,
    output dword_t result
);

    localparam int CNT_W = $clog2(`DIV_STEPS + 1);

    div_state_t       state;
    logic [CNT_W-1:0] step_cnt;

    word_t       quo;        // dividend bits out the top, quotient bits in the bottom
    word_t       rem;        // partial remainder
    word_t       dvs_mag;
    logic        quo_neg;
    logic        rem_neg;    // remainder follows the dividend sign
    logic [32:0] rem_shift;
    logic        fits;       // trial subtraction does not borrow
    word_t       rem_diff;

    assign rem_shift = {rem, quo[31]};
    assign fits      = rem_shift >= {1'b0, dvs_mag};
    assign rem_diff  = word_t'(rem_shift - {1'b0, dvs_mag});
    assign done      = (state == DIV_DONE);

    always_ff @(posedge clk) begin
        if (rst || flush) begin
            state    <= DIV_IDLE;
            step_cnt <= '0;
        end else begin
            case (state)
                DIV_IDLE, DIV_DONE: begin
                    if (start) begin
                        state    <= DIV_BUSY;
                        step_cnt <= '0;
                    end else begin
                        state <= DIV_IDLE;
                    end
                end
                DIV_BUSY: begin
                    step_cnt <= step_cnt + 1'b1;
                    if (step_cnt == CNT_W'(`DIV_STEPS - 1))
                        state <= DIV_FIX;
                end
                DIV_FIX: state <= DIV_DONE;
                default: state <= DIV_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (start) begin
            quo     <= (sign && dividend[31]) ? -dividend : dividend;
            dvs_mag <= (sign && divisor[31]) ? -divisor : divisor;
            rem     <= '0;
            quo_neg <= sign & (dividend[31] ^ divisor[31]);
            rem_neg <= sign & dividend[31];
        end else if (state == DIV_BUSY) begin
            // zero divisor always fits, giving all-ones quotient
            if (fits) begin
                rem <= rem_diff;
                quo <= {quo[30:0], 1'b1};
            end else begin
                rem <= rem_shift[31:0];
                quo <= {quo[30:0], 1'b0};
            end
        end else if (state == DIV_FIX) begin
            result <= {rem_neg ? -rem : rem, quo_neg ? -quo : quo};
        end
    end

    // issue is never raised while the pipeline is stalled
    a_no_start_busy: assert property (@(posedge clk) disable iff (rst)
        start |-> (state == DIV_IDLE || state == DIV_DONE));

    a_done_pulse: assert property (@(posedge clk) disable iff (rst)
        done |=> !done);

endmodule

//--- hw/alu_simple.sv
`include "ex_defines.svh"

module alu_simple
    import ex_pkg::*;
(
    input  alu_op_t op,
    input  word_t   src_a,
    input  word_t   src_b,
    input  shamt_t  sa,
    output word_t   result,
    output logic    overflow
);

    logic [32:0] add_ext;   // sign-extended sum, bit 32 is the carry copy
    logic [32:0] sub_ext;
    shamt_t      reg_sa;    // variable shift amount

    assign add_ext = {src_a[31], src_a} + {src_b[31], src_b};
    assign sub_ext = {src_a[31], src_a} - {src_b[31], src_b};
    assign reg_sa  = src_a[4:0];

    always_comb begin
        overflow = 1'b0;
        case (op)
            `ALU_AND:  result = src_a & src_b;
            `ALU_OR:   result = src_a | src_b;
            `ALU_NOR:  result = ~(src_a | src_b);
            `ALU_XOR:  result = src_a ^ src_b;
            `ALU_ADD: begin
                result   = add_ext[31:0];
                overflow = add_ext[32] ^ add_ext[31];
            end
            `ALU_ADDU: result = src_a + src_b;   // wraps silently
            `ALU_SUB: begin
                result   = sub_ext[31:0];
                overflow = sub_ext[32] ^ sub_ext[31];
            end
            `ALU_SUBU: result = src_a - src_b;
            `ALU_SLT:  result = {{31{1'b0}}, $signed(src_a) < $signed(src_b)};
            `ALU_SLTU: result = {{31{1'b0}}, src_a < src_b};

            // register shifts
            `ALU_SLL:  result = src_b << reg_sa;
            `ALU_SRL:  result = src_b >> reg_sa;
            `ALU_SRA:  result = $signed(src_b) >>> reg_sa;   // sign fill

            // immediate shifts
            `ALU_SLL_SA: result = src_b << sa;
            `ALU_SRL_SA: result = src_b >> sa;
            `ALU_SRA_SA: result = $signed(src_b) >>> sa;

            `ALU_LUI:  result = {src_b[15:0], 16'h0000};
            `ALU_PASS: result = src_a;
            default:   result = '0;   // mult/div/mthi/mtlo handled above this block
        endcase
    end

endmodule

//--- hw/ex_pkg.sv
package ex_pkg;

    typedef logic [31:0] word_t;   // operand / alu word
    typedef logic [63:0] dword_t;  // {hi, lo}
    typedef logic [4:0]  shamt_t;
    typedef logic [4:0]  alu_op_t;

    // divider sequencing
    typedef enum logic [1:0] {
        DIV_IDLE,
        DIV_BUSY,
        DIV_FIX,   // apply quotient and remainder signs
        DIV_DONE
    } div_state_t;

    // multiplier sequencing
    typedef enum logic [1:0] {
        MULT_IDLE,
        MULT_BUSY,
        MULT_FIX,  // negate product if needed
        MULT_DONE
    } mult_state_t;

endpackage

//--- hw/ex_defines.svh
`ifndef EX_DEFINES_SVH
`define EX_DEFINES_SVH

// execute stage operation codes, 5 bits
`define ALU_AND            5'd0
`define ALU_OR             5'd1
`define ALU_NOR            5'd2
`define ALU_XOR            5'd3
`define ALU_ADD            5'd4   // signed, traps on overflow
`define ALU_ADDU           5'd5
`define ALU_SUB            5'd6   // signed, traps on overflow
`define ALU_SUBU           5'd7
`define ALU_SLT            5'd8
`define ALU_SLTU           5'd9
`define ALU_SLL            5'd10  // shift amount from src_a
`define ALU_SRL            5'd11
`define ALU_SRA            5'd12
`define ALU_SLL_SA         5'd13  // shift amount from sa field
`define ALU_SRL_SA         5'd14
`define ALU_SRA_SA         5'd15
`define ALU_LUI            5'd16
`define ALU_PASS           5'd17
`define ALU_MTHI           5'd18
`define ALU_MTLO           5'd19
`define ALU_SIGNED_MULT    5'd20
`define ALU_UNSIGNED_MULT  5'd21
`define ALU_SIGNED_DIV     5'd22
`define ALU_UNSIGNED_DIV   5'd23

// iterations of the multi-cycle units
`define DIV_STEPS          32     // one quotient bit per step
`define MULT_STEPS         16     // two multiplier bits per step

`endif
